//--- logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int unsigned xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // one-hot alu select, bit positions below
  typedef logic [11:0] alu_op_t;

  localparam int unsigned alu_add  = 0;
  localparam int unsigned alu_sub  = 1;
  localparam int unsigned alu_slt  = 2;
  localparam int unsigned alu_sltu = 3;
  localparam int unsigned alu_and  = 4;
  localparam int unsigned alu_nor  = 5;
  localparam int unsigned alu_or   = 6;
  localparam int unsigned alu_xor  = 7;
  localparam int unsigned alu_sll  = 8;
  localparam int unsigned alu_srl  = 9;
  localparam int unsigned alu_sra  = 10;
  localparam int unsigned alu_lui  = 11;

  // major group 0 holds 3r ops, immediate shifts and addi.w
  localparam logic [5:0] op_grp0        = 6'h00;
  localparam logic [3:0] op_sub_3r      = 4'h0;
  localparam logic [1:0] op_sub_3r_lo   = 2'h1;
  localparam logic [3:0] op_sub_shift   = 4'h1;
  localparam logic [1:0] op_sub_shift_lo = 2'h0;
  localparam logic [3:0] op_sub_addi_w  = 4'ha;

  localparam logic [4:0] fn_add_w  = 5'h00;
  localparam logic [4:0] fn_sub_w  = 5'h02;
  localparam logic [4:0] fn_slt    = 5'h04;
  localparam logic [4:0] fn_sltu   = 5'h05;
  localparam logic [4:0] fn_nor    = 5'h08;
  localparam logic [4:0] fn_and    = 5'h09;
  localparam logic [4:0] fn_or     = 5'h0a;
  localparam logic [4:0] fn_xor    = 5'h0b;
  localparam logic [4:0] fn_slli_w = 5'h01;
  localparam logic [4:0] fn_srli_w = 5'h09;
  localparam logic [4:0] fn_srai_w = 5'h11;

  // lu12i.w matches on inst[31:25]
  localparam logic [6:0] op_lu12i_w = 7'h0a;

  localparam logic [5:0] op_grp_mem = 6'h0a;
  localparam logic [3:0] mem_ld_w   = 4'h2;
  localparam logic [3:0] mem_st_w   = 4'h6;

  localparam logic [5:0] op_jirl = 6'h13;
  localparam logic [5:0] op_b    = 6'h14;
  localparam logic [5:0] op_bl   = 6'h15;
  localparam logic [5:0] op_beq  = 6'h16;
  localparam logic [5:0] op_bne  = 6'h17;
  localparam logic [5:0] op_blt  = 6'h18;
  localparam logic [5:0] op_bge  = 6'h19;
  localparam logic [5:0] op_bltu = 6'h1a;
  localparam logic [5:0] op_bgeu = 6'h1b;

  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_b,
    br_bl,
    br_jirl
  } branch_kind_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic            we;
    reg_addr_t       addr;
    logic [xlen-1:0] data;
  } wb_write_t;

  // busy: producer matched but its result is not out yet
  typedef struct packed {
    logic            busy;
    logic            en;
    reg_addr_t       addr;
    logic [xlen-1:0] data;
  } fwd_src_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } br_req_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      load_op;
    logic      store_op;
    logic      res_from_mem;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      gr_we;
    reg_addr_t dest;
  } ds_ctrl_t;

  typedef struct packed {
    ds_ctrl_t        ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
    logic [xlen-1:0] pc;
  } ds_to_es_t;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
`default_nettype none

module inst_decoder import decode_pkg::*; (
  input  logic [31:0]  inst,
  output ds_ctrl_t     ctrl,
  output logic [31:0]  imm,
  output logic [31:0]  br_offs,
  output branch_kind_t br_kind,
  output reg_addr_t    raddr1,
  output reg_addr_t    raddr2,
  output logic         need_rj,
  output logic         need_rkd
);

  logic [5:0]  op_31_26;
  logic [3:0]  op_25_22;
  logic [1:0]  op_21_20;
  logic [4:0]  op_19_15;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  logic [11:0] i12;
  logic [19:0] i20;
  logic [15:0] i16;
  logic [25:0] i26;
  logic        is_3r;
  logic        is_shift;
  logic        inst_add_w;
  logic        inst_sub_w;
  logic        inst_slt;
  logic        inst_sltu;
  logic        inst_nor;
  logic        inst_and;
  logic        inst_or;
  logic        inst_xor;
  logic        inst_slli_w;
  logic        inst_srli_w;
  logic        inst_srai_w;
  logic        inst_addi_w;
  logic        inst_lu12i_w;
  logic        inst_ld_w;
  logic        inst_st_w;
  logic        inst_jirl;
  logic        inst_b;
  logic        inst_bl;
  logic        inst_beq;
  logic        inst_bne;
  logic        inst_blt;
  logic        inst_bge;
  logic        inst_bltu;
  logic        inst_bgeu;
  logic        inst_cond_br;
  logic        inst_shift_imm;
  logic        inst_alu_3r;
  logic        inst_valid;
  alu_op_t     alu_op;

  assign op_31_26 = inst[31:26];
  assign op_25_22 = inst[25:22];
  assign op_21_20 = inst[21:20];
  assign op_19_15 = inst[19:15];

  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i20 = inst[24:5];
  assign i16 = inst[25:10];
  // offs[25:16] sits in the low bits of the word
  assign i26 = {inst[9:0], inst[25:10]};

  assign is_3r = (op_31_26 == op_grp0) && (op_25_22 == op_sub_3r) &&
                 (op_21_20 == op_sub_3r_lo);
  assign is_shift = (op_31_26 == op_grp0) && (op_25_22 == op_sub_shift) &&
                    (op_21_20 == op_sub_shift_lo);

  assign inst_add_w  = is_3r && (op_19_15 == fn_add_w);
  assign inst_sub_w  = is_3r && (op_19_15 == fn_sub_w);
  assign inst_slt    = is_3r && (op_19_15 == fn_slt);
  assign inst_sltu   = is_3r && (op_19_15 == fn_sltu);
  assign inst_nor    = is_3r && (op_19_15 == fn_nor);
  assign inst_and    = is_3r && (op_19_15 == fn_and);
  assign inst_or     = is_3r && (op_19_15 == fn_or);
  assign inst_xor    = is_3r && (op_19_15 == fn_xor);
  assign inst_slli_w = is_shift && (op_19_15 == fn_slli_w);
  assign inst_srli_w = is_shift && (op_19_15 == fn_srli_w);
  assign inst_srai_w = is_shift && (op_19_15 == fn_srai_w);
  assign inst_addi_w = (op_31_26 == op_grp0) && (op_25_22 == op_sub_addi_w);
  assign inst_lu12i_w = (inst[31:25] == op_lu12i_w);
  assign inst_ld_w   = (op_31_26 == op_grp_mem) && (op_25_22 == mem_ld_w);
  assign inst_st_w   = (op_31_26 == op_grp_mem) && (op_25_22 == mem_st_w);
  assign inst_jirl   = (op_31_26 == op_jirl);
  assign inst_b      = (op_31_26 == op_b);
  assign inst_bl     = (op_31_26 == op_bl);
  assign inst_beq    = (op_31_26 == op_beq);
  assign inst_bne    = (op_31_26 == op_bne);
  assign inst_blt    = (op_31_26 == op_blt);
  assign inst_bge    = (op_31_26 == op_bge);
  assign inst_bltu   = (op_31_26 == op_bltu);
  assign inst_bgeu   = (op_31_26 == op_bgeu);

  assign inst_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign inst_shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
  assign inst_alu_3r = inst_add_w | inst_sub_w | inst_slt | inst_sltu |
                       inst_nor | inst_and | inst_or | inst_xor;
  assign inst_valid = inst_alu_3r | inst_shift_imm | inst_addi_w | inst_lu12i_w |
                      inst_ld_w | inst_st_w | inst_cond_br |
                      inst_jirl | inst_b | inst_bl;

  // link address for jirl/bl is pc + 4 through the adder
  assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w |
                            inst_jirl | inst_bl;
  assign alu_op[alu_sub]  = inst_sub_w;
  assign alu_op[alu_slt]  = inst_slt;
  assign alu_op[alu_sltu] = inst_sltu;
  assign alu_op[alu_and]  = inst_and;
  assign alu_op[alu_nor]  = inst_nor;
  assign alu_op[alu_or]   = inst_or;
  assign alu_op[alu_xor]  = inst_xor;
  assign alu_op[alu_sll]  = inst_slli_w;
  assign alu_op[alu_srl]  = inst_srli_w;
  assign alu_op[alu_sra]  = inst_srai_w;
  assign alu_op[alu_lui]  = inst_lu12i_w;

  always_comb begin
    ctrl.alu_op       = alu_op;
    ctrl.load_op      = inst_ld_w;
    ctrl.store_op     = inst_st_w;
    ctrl.res_from_mem = inst_ld_w;
    ctrl.src1_is_pc   = inst_jirl | inst_bl;
    ctrl.src2_is_imm  = inst_shift_imm | inst_addi_w | inst_lu12i_w | inst_ld_w |
                        inst_st_w | inst_jirl | inst_bl;
    ctrl.gr_we        = inst_valid & ~inst_st_w & ~inst_cond_br & ~inst_b;
    if (!inst_valid) begin
      ctrl.dest = 5'd0;
    end else if (inst_bl) begin
      ctrl.dest = 5'd1;
    end else begin
      ctrl.dest = rd;
    end
  end

  always_comb begin
    if (inst_jirl || inst_bl) begin
      imm = 32'd4;
    end else if (inst_lu12i_w) begin
      imm = {i20, 12'b0};
    end else if (inst_shift_imm) begin
      imm = {27'b0, rk};
    end else begin
      imm = {{20{i12[11]}}, i12};
    end
  end

  assign br_offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                         {{14{i16[15]}}, i16, 2'b0};

  always_comb begin
    br_kind = br_none;
    if (inst_beq) br_kind = br_beq;
    else if (inst_bne) br_kind = br_bne;
    else if (inst_blt) br_kind = br_blt;
    else if (inst_bge) br_kind = br_bge;
    else if (inst_bltu) br_kind = br_bltu;
    else if (inst_bgeu) br_kind = br_bgeu;
    else if (inst_b) br_kind = br_b;
    else if (inst_bl) br_kind = br_bl;
    else if (inst_jirl) br_kind = br_jirl;
  end

  assign raddr1 = rj;
  assign raddr2 = (inst_cond_br || inst_st_w) ? rd : rk;

  assign need_rj  = inst_alu_3r | inst_shift_imm | inst_addi_w | inst_ld_w |
                    inst_st_w | inst_cond_br | inst_jirl;
  assign need_rkd = inst_alu_3r | inst_cond_br | inst_st_w;

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file import decode_pkg::*; (
  input  logic            clk,
  input  reg_addr_t       raddr1,
  input  reg_addr_t       raddr2,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,
  input  wb_write_t       wr
);

  logic [xlen-1:0] regs [0:31];

  always_ff @(posedge clk) begin
    if (wr.we && wr.addr != 5'd0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // r0 hardwired, same-cycle write shows up next cycle
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  a_we_addr_known : assert property (
    @(posedge clk) wr.we |-> !$isunknown(wr.addr)
  );

endmodule

`default_nettype wire

//--- logic/operand_bypass.sv
`default_nettype none

module operand_bypass import decode_pkg::*; (
  input  reg_addr_t       raddr,
  input  logic            need,
  input  fwd_src_t        es_fwd,
  input  fwd_src_t        ms_fwd,
  input  wb_write_t       ws_write,
  input  logic [xlen-1:0] rf_data,
  output logic [xlen-1:0] value,
  output logic            stall
);

  logic lookup;
  logic hit_es;
  logic hit_ms;
  logic hit_ws;

  // r0 is constant, never take a forward for it
  assign lookup = need && (raddr != 5'd0);

  assign hit_es = lookup && es_fwd.en && (es_fwd.addr == raddr);
  assign hit_ms = lookup && ms_fwd.en && (ms_fwd.addr == raddr);
  assign hit_ws = lookup && ws_write.we && (ws_write.addr == raddr);

  // youngest producer first
  always_comb begin
    if (hit_es) begin
      value = es_fwd.data;
      stall = es_fwd.busy;
    end else if (hit_ms) begin
      value = ms_fwd.data;
      stall = ms_fwd.busy;
    end else if (hit_ws) begin
      value = ws_write.data;
      stall = 1'b0;
    end else begin
      value = rf_data;
      stall = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`default_nettype none

module branch_unit import decode_pkg::*; (
  input  logic            fire,
  input  branch_kind_t    br_kind,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] br_offs,
  input  logic [xlen-1:0] rj_value,
  input  logic [xlen-1:0] rkd_value,
  output br_req_t         br
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond;
  logic [xlen-1:0] base;

  assign eq   = (rj_value == rkd_value);
  assign lt_u = (rj_value < rkd_value);
  assign lt_s = ($signed(rj_value) < $signed(rkd_value));

  always_comb begin
    case (br_kind)
      br_beq:  cond = eq;
      br_bne:  cond = !eq;
      br_blt:  cond = lt_s;
      br_bge:  cond = !lt_s;
      br_bltu: cond = lt_u;
      br_bgeu: cond = !lt_u;
      br_b,
      br_bl,
      br_jirl: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  // only jirl is register-relative
  assign base = (br_kind == br_jirl) ? rj_value : pc;

  assign br = '{taken: fire && cond, target: base + br_offs};

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       fs_to_ds_valid,
  input  fetch_pkt_t fs_to_ds,
  output logic       ds_allowin,
  input  logic       es_allowin,
  output logic       ds_to_es_valid,
  output ds_to_es_t  ds_to_es,
  input  fwd_src_t   es_fwd,
  input  fwd_src_t   ms_fwd,
  input  wb_write_t  ws_write,
  output br_req_t    br
);

  logic            ds_valid;
  fetch_pkt_t      ds_pkt;
  logic            ds_ready_go;
  logic            handoff;
  ds_ctrl_t        ctrl;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] br_offs;
  branch_kind_t    br_kind;
  reg_addr_t       raddr1;
  reg_addr_t       raddr2;
  logic            need_rj;
  logic            need_rkd;
  logic [xlen-1:0] rf_rdata1;
  logic [xlen-1:0] rf_rdata2;
  logic [xlen-1:0] rj_value;
  logic [xlen-1:0] rkd_value;
  logic            stall1;
  logic            stall2;

  assign ds_ready_go    = !(stall1 || stall2);
  assign ds_to_es_valid = ds_valid && ds_ready_go;
  assign handoff        = ds_to_es_valid && es_allowin;
  assign ds_allowin     = !ds_valid || handoff;

  // taken branch empties the stage and drops the wrong-path packet
  always_ff @(posedge clk) begin
    if (rst) begin
      ds_valid <= 1'b0;
    end else if (br.taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_to_ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs_to_ds_valid && ds_allowin) begin
      ds_pkt <= fs_to_ds;
    end
  end

  inst_decoder u_dec (
    .inst     (ds_pkt.inst),
    .ctrl     (ctrl),
    .imm      (imm),
    .br_offs  (br_offs),
    .br_kind  (br_kind),
    .raddr1   (raddr1),
    .raddr2   (raddr2),
    .need_rj  (need_rj),
    .need_rkd (need_rkd)
  );

  reg_file u_rf (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wr     (ws_write)
  );

  operand_bypass u_src1 (
    .raddr    (raddr1),
    .need     (need_rj),
    .es_fwd   (es_fwd),
    .ms_fwd   (ms_fwd),
    .ws_write (ws_write),
    .rf_data  (rf_rdata1),
    .value    (rj_value),
    .stall    (stall1)
  );

  operand_bypass u_src2 (
    .raddr    (raddr2),
    .need     (need_rkd),
    .es_fwd   (es_fwd),
    .ms_fwd   (ms_fwd),
    .ws_write (ws_write),
    .rf_data  (rf_rdata2),
    .value    (rkd_value),
    .stall    (stall2)
  );

  branch_unit u_br (
    .fire      (handoff),
    .br_kind   (br_kind),
    .pc        (ds_pkt.pc),
    .br_offs   (br_offs),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .br        (br)
  );

  assign ds_to_es = '{
    ctrl:      ctrl,
    imm:       imm,
    rj_value:  rj_value,
    rkd_value: rkd_value,
    pc:        ds_pkt.pc
  };

  a_taken_on_handoff : assert property (
    @(posedge clk) disable iff (rst) br.taken |-> ds_to_es_valid && es_allowin
  );

endmodule

`default_nettype wire

//--- verif/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb import decode_pkg::*;;
  timeunit 1ns;
  timeprecision 1ns;

  typedef enum logic [4:0] {
    m_add, m_sub, m_slt, m_sltu, m_nor, m_and, m_or, m_xor, m_slli, m_srli, m_srai,
    m_addi, m_lu12i, m_ld, m_st, m_jirl, m_b, m_bl, m_beq, m_bne, m_blt, m_bge,
    m_bltu, m_bgeu
  } mnem_t;

  logic clk = 1'b0;
  logic rst;
  logic fs_to_ds_valid;
  fetch_pkt_t fs_to_ds;
  logic ds_allowin;
  logic es_allowin;
  logic ds_to_es_valid;
  ds_to_es_t ds_to_es;
  fwd_src_t es_fwd;
  fwd_src_t ms_fwd;
  wb_write_t ws_write;
  br_req_t br;

  // reference model state
  logic [31:0] shadow [0:31];
  logic held_valid;
  fetch_pkt_t held_pkt;
  mnem_t held_m;
  mnem_t offer_m;
  ds_to_es_t exp_out;
  logic exp_stall;
  logic exp_taken;
  logic [31:0] exp_target;
  logic handoff;
  logic exp_allowin;
  logic bp_mode;
  logic [31:0] pc_next;
  int errors = 0;
  int handed = 0;
  int accepted = 0;
  int dropped = 0;
  int tests = 0;

  decode_stage uut (.*);

  always #50 clk = ~clk;

  function automatic logic [32:0] pick_operand(reg_addr_t a, logic need, fwd_src_t e,
                                               fwd_src_t m, wb_write_t w, logic [31:0] rf);
    if (need && a != 5'd0 && e.en && e.addr == a) return {e.busy, e.data};
    if (need && a != 5'd0 && m.en && m.addr == a) return {m.busy, m.data};
    if (need && a != 5'd0 && w.we && w.addr == a) return {1'b0, w.data};
    return {1'b0, rf};
  endfunction

  always_comb begin
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t r2;
    logic nj;
    logic nk;
    logic [32:0] s1;
    logic [32:0] s2;
    logic [31:0] offs;
    logic [25:0] i26;
    logic c;
    rd = held_pkt.inst[4:0];
    rj = held_pkt.inst[9:5];
    i26 = {held_pkt.inst[9:0], held_pkt.inst[25:10]};
    exp_out = '0;
    exp_out.pc = held_pkt.pc;
    exp_out.ctrl.dest = (held_m == m_bl) ? 5'd1 : rd;
    exp_out.ctrl.gr_we = !(held_m inside {m_st, m_b, m_beq, m_bne, m_blt, m_bge, m_bltu, m_bgeu});
    exp_out.ctrl.load_op = (held_m == m_ld);
    exp_out.ctrl.res_from_mem = (held_m == m_ld);
    exp_out.ctrl.store_op = (held_m == m_st);
    exp_out.ctrl.src1_is_pc = held_m inside {m_jirl, m_bl};
    exp_out.ctrl.src2_is_imm = held_m inside {m_slli, m_srli, m_srai, m_addi, m_lu12i, m_ld,
                                              m_st, m_jirl, m_bl};
    case (held_m)
      m_add, m_addi, m_ld, m_st, m_jirl, m_bl: exp_out.ctrl.alu_op[0] = 1'b1;
      m_sub:   exp_out.ctrl.alu_op[1] = 1'b1;
      m_slt:   exp_out.ctrl.alu_op[2] = 1'b1;
      m_sltu:  exp_out.ctrl.alu_op[3] = 1'b1;
      m_and:   exp_out.ctrl.alu_op[4] = 1'b1;
      m_nor:   exp_out.ctrl.alu_op[5] = 1'b1;
      m_or:    exp_out.ctrl.alu_op[6] = 1'b1;
      m_xor:   exp_out.ctrl.alu_op[7] = 1'b1;
      m_slli:  exp_out.ctrl.alu_op[8] = 1'b1;
      m_srli:  exp_out.ctrl.alu_op[9] = 1'b1;
      m_srai:  exp_out.ctrl.alu_op[10] = 1'b1;
      m_lu12i: exp_out.ctrl.alu_op[11] = 1'b1;
      default: exp_out.ctrl.alu_op = '0;
    endcase
    if (held_m inside {m_jirl, m_bl}) exp_out.imm = 32'd4;
    else if (held_m == m_lu12i) exp_out.imm = {held_pkt.inst[24:5], 12'b0};
    else if (held_m inside {m_slli, m_srli, m_srai}) exp_out.imm = {27'b0, held_pkt.inst[14:10]};
    else exp_out.imm = {{20{held_pkt.inst[21]}}, held_pkt.inst[21:10]};
    nj = !(held_m inside {m_lu12i, m_b, m_bl});
    nk = held_m inside {m_add, m_sub, m_slt, m_sltu, m_nor, m_and, m_or, m_xor, m_st,
                        m_beq, m_bne, m_blt, m_bge, m_bltu, m_bgeu};
    r2 = (held_m inside {m_st, m_beq, m_bne, m_blt, m_bge, m_bltu, m_bgeu}) ? rd :
         held_pkt.inst[14:10];
    s1 = pick_operand(rj, nj, es_fwd, ms_fwd, ws_write, (rj == 5'd0) ? 32'd0 : shadow[rj]);
    s2 = pick_operand(r2, nk, es_fwd, ms_fwd, ws_write, (r2 == 5'd0) ? 32'd0 : shadow[r2]);
    exp_out.rj_value = s1[31:0];
    exp_out.rkd_value = s2[31:0];
    exp_stall = s1[32] || s2[32];
    case (held_m)
      m_beq:   c = (s1[31:0] == s2[31:0]);
      m_bne:   c = (s1[31:0] != s2[31:0]);
      m_blt:   c = ($signed(s1[31:0]) < $signed(s2[31:0]));
      m_bge:   c = ($signed(s1[31:0]) >= $signed(s2[31:0]));
      m_bltu:  c = (s1[31:0] < s2[31:0]);
      m_bgeu:  c = (s1[31:0] >= s2[31:0]);
      m_b, m_bl, m_jirl: c = 1'b1;
      default: c = 1'b0;
    endcase
    exp_taken = c;
    if (held_m inside {m_b, m_bl}) offs = {{4{i26[25]}}, i26, 2'b0};
    else offs = {{14{held_pkt.inst[25]}}, held_pkt.inst[25:10], 2'b0};
    exp_target = ((held_m == m_jirl) ? s1[31:0] : held_pkt.pc) + offs;
  end

  assign handoff = held_valid && !exp_stall && es_allowin;
  assign exp_allowin = !held_valid || handoff;

  always @(posedge clk) begin
    if (ws_write.we && ws_write.addr != 5'd0) shadow[ws_write.addr] <= ws_write.data;
    if (rst) begin
      held_valid <= 1'b0;
    end else begin
      // handoffs seen at the DUT boundary
      if (ds_to_es_valid && es_allowin) begin
        handed++;
      end
      if (handoff) begin
        held_valid <= 1'b0;
      end
      // a taken branch kills the packet offered alongside it
      if (fs_to_ds_valid && exp_allowin && handoff && exp_taken) begin
        dropped++;
      end else if (fs_to_ds_valid && exp_allowin) begin
        held_valid <= 1'b1;
        held_pkt <= fs_to_ds;
        held_m <= offer_m;
        accepted++;
      end
    end
  end

  a_reset_quiet : assert property (@(posedge clk) rst && $past(rst) |->
    !ds_to_es_valid && !br.taken && ds_allowin)
    else begin errors++; $display("reset outputs are not idle at %0t", $time); end
  a_valid : assert property (@(posedge clk) disable iff (rst)
    ds_to_es_valid == (held_valid && !exp_stall))
    else begin errors++; $display("Error: %0t ds_to_es_valid expected %b got %b", $time,
      $sampled(held_valid && !exp_stall), $sampled(ds_to_es_valid)); end
  a_allowin : assert property (@(posedge clk) disable iff (rst)
    ds_allowin == exp_allowin)
    else begin errors++; $display("Error: %0t ds_allowin expected %b got %b", $time,
      $sampled(exp_allowin), $sampled(ds_allowin)); end
  a_fields : assert property (@(posedge clk) disable iff (rst)
    ds_to_es_valid |-> ds_to_es == exp_out)
    else begin errors++; $display("Error: %0t ds_to_es expected %h got %h", $time,
      $sampled(exp_out), $sampled(ds_to_es)); end
  a_taken : assert property (@(posedge clk) disable iff (rst)
    br.taken == (handoff && exp_taken))
    else begin errors++; $display("Error: %0t br.taken expected %b got %b", $time,
      $sampled(handoff && exp_taken), $sampled(br.taken)); end
  a_target : assert property (@(posedge clk) disable iff (rst)
    br.taken |-> br.target == exp_target)
    else begin errors++; $display("Error: %0t br.target expected %h got %h", $time,
      $sampled(exp_target), $sampled(br.target)); end
  a_hold : assert property (@(posedge clk) disable iff (rst)
    bp_mode && ds_to_es_valid && !es_allowin |=> $stable(ds_to_es) && ds_to_es_valid)
    else begin errors++; $display("held packet changed under back-pressure at %0t", $time); end

  always @(posedge clk) begin
    logic [31:0] r;
    r = $urandom;
    #1;
    if (bp_mode) es_allowin = r[0];
  end

  task automatic abort_run(input string why);
    $display("timeout: %s at %0t", why, $time);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  function automatic logic [31:0] encode(mnem_t m);
    logic [31:0] r;
    logic [31:0] f;
    logic [4:0] rd;
    logic [4:0] rj;
    r = $urandom;
    f = $urandom;
    rd = r[4:0];
    rj = r[9:5];
    if (r[31:30] == 2'b00) rd = rj;
    case (m)
      m_add:   return {10'h000, 2'b01, 5'h00, r[14:10], rj, rd};
      m_sub:   return {10'h000, 2'b01, 5'h02, r[14:10], rj, rd};
      m_slt:   return {10'h000, 2'b01, 5'h04, r[14:10], rj, rd};
      m_sltu:  return {10'h000, 2'b01, 5'h05, r[14:10], rj, rd};
      m_nor:   return {10'h000, 2'b01, 5'h08, r[14:10], rj, rd};
      m_and:   return {10'h000, 2'b01, 5'h09, r[14:10], rj, rd};
      m_or:    return {10'h000, 2'b01, 5'h0a, r[14:10], rj, rd};
      m_xor:   return {10'h000, 2'b01, 5'h0b, r[14:10], rj, rd};
      m_slli:  return {6'h00, 4'h1, 2'b00, 5'h01, r[14:10], rj, rd};
      m_srli:  return {6'h00, 4'h1, 2'b00, 5'h09, r[14:10], rj, rd};
      m_srai:  return {6'h00, 4'h1, 2'b00, 5'h11, r[14:10], rj, rd};
      m_addi:  return {6'h00, 4'ha, f[11:0], rj, rd};
      m_lu12i: return {7'h0a, f[19:0], rd};
      m_ld:    return {6'h0a, 4'h2, f[11:0], rj, rd};
      m_st:    return {6'h0a, 4'h6, f[11:0], rj, rd};
      m_jirl:  return {6'h13, f[15:0], rj, rd};
      m_b:     return {6'h14, f[25:0]};
      m_bl:    return {6'h15, f[25:0]};
      m_beq:   return {6'h16, f[15:0], rj, rd};
      m_bne:   return {6'h17, f[15:0], rj, rd};
      m_blt:   return {6'h18, f[15:0], rj, rd};
      m_bge:   return {6'h19, f[15:0], rj, rd};
      m_bltu:  return {6'h1a, f[15:0], rj, rd};
      default: return {6'h1b, f[15:0], rj, rd};
    endcase
  endfunction

  task automatic offer_pkt(input mnem_t m, input logic [31:0] inst);
    int n;
    logic go;
    fs_to_ds_valid = 1'b1;
    fs_to_ds = '{pc: pc_next, inst: inst};
    offer_m = m;
    pc_next = pc_next + 32'd4;
    n = 0;
    go = 1'b0;
    while (!go) begin
      @(negedge clk);
      go = ds_allowin;
      @(posedge clk);
      #1;
      n++;
      if (!go && n > 40) abort_run("fetch packet never accepted");
    end
    fs_to_ds_valid = 1'b0;
  endtask

  task automatic drain_stage();
    int n;
    n = 0;
    while (held_valid) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 60) abort_run("held packet never handed off");
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - e0);
  endtask

  task automatic set_fwd(input logic sel_ms, input logic busy, input reg_addr_t a,
                         input logic [31:0] d);
    if (sel_ms) ms_fwd = '{busy: busy, en: 1'b1, addr: a, data: d};
    else es_fwd = '{busy: busy, en: 1'b1, addr: a, data: d};
  endtask

  initial begin
    int e0;
    logic [31:0] inst;
    mnem_t m;
    void'($urandom(32'h1bc6dc83));
    rst = 1'b1;
    fs_to_ds_valid = 1'b0;
    fs_to_ds = '0;
    offer_m = m_add;
    es_allowin = 1'b1;
    es_fwd = '0;
    ms_fwd = '0;
    ws_write = '0;
    bp_mode = 1'b0;
    pc_next = {$urandom} & 32'hffff_fffc;
    e0 = errors;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    report_test("reset", e0);

    // preload while the stage is empty
    for (int i = 1; i < 32; i++) begin
      ws_write = '{we: 1'b1, addr: 5'(i), data: $urandom};
      @(posedge clk);
      #1;
    end
    ws_write = '0;

    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      for (int i = int'(m_add); i <= int'(m_lu12i); i++) begin
        offer_pkt(mnem_t'(i), encode(mnem_t'(i)));
        drain_stage();
      end
    end
    report_test("alu and immediate decode", e0);

    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      offer_pkt(m_ld, encode(m_ld));
      offer_pkt(m_st, encode(m_st));
      drain_stage();
    end
    report_test("loads and stores", e0);

    e0 = errors;
    for (int k = 0; k < 8; k++) begin
      inst = encode(m_add);
      // r0 source with forwards aimed at r0
      if (k == 2) inst[9:5] = 5'd0;
      set_fwd(1'b0, 1'b0, inst[9:5], $urandom);
      set_fwd(1'b1, 1'b0, inst[9:5], $urandom);
      ws_write = '{we: 1'b1, addr: inst[14:10], data: $urandom};
      if (k == 1) es_fwd.en = 1'b0;
      offer_pkt(m_add, inst);
      drain_stage();
      es_fwd.busy = (k < 4);
      ms_fwd.busy = (k >= 4);
      if (k >= 4) es_fwd.en = 1'b0;
      offer_pkt(m_add, inst);
      repeat (3) @(posedge clk);
      #1;
      es_fwd.busy = 1'b0;
      ms_fwd.busy = 1'b0;
      drain_stage();
      es_fwd = '0;
      ms_fwd = '0;
      ws_write = '0;
    end
    report_test("forwarding and stalls", e0);

    e0 = errors;
    for (int k = 0; k < 6; k++) begin
      for (int i = int'(m_jirl); i <= int'(m_bgeu); i++) begin
        offer_pkt(mnem_t'(i), encode(mnem_t'(i)));
        // wrong-path candidate offered in the handoff cycle
        fs_to_ds_valid = 1'b1;
        fs_to_ds = '{pc: pc_next, inst: encode(m_xor)};
        offer_m = m_xor;
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b0;
        drain_stage();
      end
    end
    report_test("branches", e0);

    e0 = errors;
    accepted = 0;
    handed = 0;
    dropped = 0;
    bp_mode = 1'b1;
    for (int k = 0; k < 120; k++) begin
      m = mnem_t'($urandom % 24);
      offer_pkt(m, encode(m));
    end
    drain_stage();
    bp_mode = 1'b0;
    es_allowin = 1'b1;
    if (accepted != handed) begin
      errors++;
      $display("handed-off packets (%0d) differ from accepted packets (%0d)", handed, accepted);
    end
    report_test("back-pressure", e0);

    $display("tests %0d, handoffs %0d, dropped %0d, errors %0d", tests, handed, dropped, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module decode_stage_tb -f list.f -o tb
	./obj_dir/tb | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
